/* verilog/eth_frame_pkg.sv */
// Frame-level types of the Ethernet frame router, shared by the RTL and the testbench
`default_nettype none

package eth_frame_pkg;

    // station address, most significant octet first on the wire
    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] eth_type_t;

    // header as it arrives in one transfer, 112 bits
    typedef struct packed {
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        eth_type_t eth_type;
    } eth_hdr_t;

    // one payload byte with its framing flags
    // last marks the final byte of a frame
    // user is the error flag and is never altered in the router
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } eth_beat_t;

    // known EtherType values used for classification
    localparam eth_type_t ETH_TYPE_IPV4 = 16'h0800;
    localparam eth_type_t ETH_TYPE_ARP  = 16'h0806;
    localparam eth_type_t ETH_TYPE_IPV6 = 16'h86DD;

endpackage

`default_nettype wire

/* verilog/eth_route_pkg.sv */
// Routing types of the Ethernet frame router: port numbers, traffic classes, demux states
`default_nettype none

package eth_route_pkg;

    // output port number, room for up to 4 ports
    typedef logic [1:0] port_idx_t;

    // traffic classes share the port encoding
    // a class maps straight onto the port of the same number
    localparam port_idx_t CLASS_IPV4  = 2'd0;
    localparam port_idx_t CLASS_ARP   = 2'd1;
    localparam port_idx_t CLASS_IPV6  = 2'd2;
    localparam port_idx_t CLASS_OTHER = 2'd3;

    // demux frame state
    // ST_IDLE waits for a routed header
    // ST_FRAME passes payload until the beat with last is accepted
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_FRAME = 1'b1
    } demux_state_t;

endpackage

`default_nettype wire

/* verilog/eth_route_lookup.sv */
// Stage 1 of the frame router: classifies each header by EtherType and holds it with its port
`default_nettype none

module eth_route_lookup #(
    parameter int NUM_PORTS = 4
) (
    input  wire                       clk,
    input  wire                       rst,

    // header from outside
    input  wire eth_frame_pkg::eth_hdr_t hdr_in,
    input  wire                       hdr_in_valid,
    output logic                      hdr_in_ready,

    // routed header to the demux
    output eth_frame_pkg::eth_hdr_t   route_hdr,
    output eth_route_pkg::port_idx_t  route_port,
    output logic                      route_valid,
    input  wire                       route_ready
);

    // classes at or above the last port all share it
    localparam eth_route_pkg::port_idx_t LAST_PORT =
        eth_route_pkg::port_idx_t'(NUM_PORTS - 1);

    eth_route_pkg::port_idx_t cls;
    eth_route_pkg::port_idx_t port_d;

    logic live_q;
    logic valid_q;
    logic load;
    logic pop;

    // traffic class from the EtherType
    always_comb begin
        case (hdr_in.eth_type)
            eth_frame_pkg::ETH_TYPE_IPV4: cls = eth_route_pkg::CLASS_IPV4;
            eth_frame_pkg::ETH_TYPE_ARP:  cls = eth_route_pkg::CLASS_ARP;
            eth_frame_pkg::ETH_TYPE_IPV6: cls = eth_route_pkg::CLASS_IPV6;
            default:                      cls = eth_route_pkg::CLASS_OTHER;
        endcase
    end

    assign port_d = (cls >= LAST_PORT) ? LAST_PORT : cls;

    // one-entry stage, refilled in the same cycle the demux drains it
    assign hdr_in_ready = live_q && (!valid_q || route_ready);
    assign load = hdr_in_valid && hdr_in_ready;
    assign pop  = valid_q && route_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // input held off until the first edge after reset
            live_q <= 1'b1;
            if (load) begin
                valid_q <= 1'b1;
            end else if (pop) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            route_hdr  <= hdr_in;
            route_port <= port_d;
        end
    end

    assign route_valid = valid_q;

endmodule

`default_nettype wire

/* verilog/eth_demux.sv */
// Stage 2 of the frame router: steers a header and its payload to the routed output port
`default_nettype none

module eth_demux #(
    parameter int NUM_PORTS = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          enable,

    // routed header from the lookup
    input  wire eth_frame_pkg::eth_hdr_t    route_hdr,
    input  wire eth_route_pkg::port_idx_t   route_port,
    input  wire                          route_valid,
    output logic                         route_ready,

    // payload from outside
    input  wire eth_frame_pkg::eth_beat_t   pay_in,
    input  wire                          pay_in_valid,
    output logic                         pay_in_ready,

    // outputs, data shared, handshake per port
    output eth_frame_pkg::eth_hdr_t      hdr_out,
    output logic [NUM_PORTS-1:0]         hdr_out_valid,
    input  wire [NUM_PORTS-1:0]          hdr_out_ready,
    output eth_frame_pkg::eth_beat_t     pay_out,
    output logic [NUM_PORTS-1:0]         pay_out_valid,
    input  wire [NUM_PORTS-1:0]          pay_out_ready
);

    eth_route_pkg::demux_state_t state_q;
    eth_route_pkg::demux_state_t state_d;
    eth_route_pkg::port_idx_t    port_q;
    eth_route_pkg::port_idx_t    port_d;

    logic                 route_ready_q;
    logic                 route_ready_d;
    logic                 pay_in_ready_q;
    logic                 pay_in_ready_d;
    logic [NUM_PORTS-1:0] hdr_valid_q;
    logic [NUM_PORTS-1:0] hdr_valid_d;
    eth_frame_pkg::eth_hdr_t hdr_q;
    logic                 hdr_load;
    logic                 start;
    logic                 beat_acc;

    // payload path, output register plus skid register
    eth_frame_pkg::eth_beat_t out_q;
    eth_frame_pkg::eth_beat_t temp_q;
    logic out_valid_q;
    logic out_valid_d;
    logic temp_valid_q;
    logic temp_valid_d;
    logic ready_int_q;
    logic ready_int_early;
    logic int_valid;
    logic cur_ready;
    logic store_int_to_out;
    logic store_int_to_temp;
    logic store_temp_to_out;

    // hdr_out and pay_out are shared by all ports,
    // so a new frame waits until every port has drained
    assign start = (state_q == eth_route_pkg::ST_IDLE) && route_valid && enable &&
                   !(|hdr_valid_q) && !out_valid_q && !temp_valid_q;

    assign beat_acc = pay_in_valid && pay_in_ready_q;

    always_comb begin
        state_d     = state_q;
        port_d      = port_q;
        hdr_load    = 1'b0;
        // header valid drops once its port takes it
        hdr_valid_d = hdr_valid_q & ~hdr_out_ready;

        case (state_q)
            eth_route_pkg::ST_IDLE: begin
                if (start) begin
                    state_d              = eth_route_pkg::ST_FRAME;
                    port_d               = route_port;
                    hdr_load             = 1'b1;
                    hdr_valid_d[route_port] = 1'b1;
                end
            end
            eth_route_pkg::ST_FRAME: begin
                if (beat_acc && pay_in.last) begin
                    state_d = eth_route_pkg::ST_IDLE;
                end
            end
            default: state_d = eth_route_pkg::ST_IDLE;
        endcase

        route_ready_d  = hdr_load;
        pay_in_ready_d = ready_int_early && (state_d == eth_route_pkg::ST_FRAME);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= eth_route_pkg::ST_IDLE;
            port_q         <= '0;
            route_ready_q  <= 1'b0;
            pay_in_ready_q <= 1'b0;
            hdr_valid_q    <= '0;
        end else begin
            state_q        <= state_d;
            port_q         <= port_d;
            route_ready_q  <= route_ready_d;
            pay_in_ready_q <= pay_in_ready_d;
            hdr_valid_q    <= hdr_valid_d;
        end
    end

    assign cur_ready = pay_out_ready[port_q];
    assign int_valid = beat_acc;

    // ready next cycle if the port takes data now, or if a beat
    // arriving next cycle still finds a free register
    assign ready_int_early = cur_ready ||
                             (!temp_valid_q && (!out_valid_q || !int_valid));

    always_comb begin
        out_valid_d       = out_valid_q;
        temp_valid_d      = temp_valid_q;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_int_q) begin
            if (cur_ready || !out_valid_q) begin
                out_valid_d      = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // port stalled, park the beat in flight
                temp_valid_d      = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (cur_ready) begin
            out_valid_d       = temp_valid_q;
            temp_valid_d      = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            temp_valid_q <= 1'b0;
            ready_int_q  <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_d;
            temp_valid_q <= temp_valid_d;
            ready_int_q  <= ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_q <= route_hdr;
        end
        if (store_int_to_out) begin
            out_q <= pay_in;
        end else if (store_temp_to_out) begin
            out_q <= temp_q;
        end
        if (store_int_to_temp) begin
            temp_q <= pay_in;
        end
    end

    // payload valid goes only to the latched port
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            pay_out_valid[i] = out_valid_q && (port_q == eth_route_pkg::port_idx_t'(i));
        end
    end

    assign hdr_out       = hdr_q;
    assign hdr_out_valid = hdr_valid_q;
    assign pay_out       = out_q;
    assign route_ready   = route_ready_q;
    assign pay_in_ready  = pay_in_ready_q;

endmodule

`default_nettype wire

/* verilog/eth_frame_router.sv */
// Top level of the Ethernet frame router: header lookup stage followed by the port demux
`default_nettype none

module eth_frame_router #(
    parameter int NUM_PORTS = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          enable,

    input  wire eth_frame_pkg::eth_hdr_t    hdr_in,
    input  wire                          hdr_in_valid,
    output logic                         hdr_in_ready,

    input  wire eth_frame_pkg::eth_beat_t   pay_in,
    input  wire                          pay_in_valid,
    output logic                         pay_in_ready,

    output eth_frame_pkg::eth_hdr_t      hdr_out,
    output logic [NUM_PORTS-1:0]         hdr_out_valid,
    input  wire [NUM_PORTS-1:0]          hdr_out_ready,

    output eth_frame_pkg::eth_beat_t     pay_out,
    output logic [NUM_PORTS-1:0]         pay_out_valid,
    input  wire [NUM_PORTS-1:0]          pay_out_ready
);

    // lookup to demux
    eth_frame_pkg::eth_hdr_t  route_hdr;
    eth_route_pkg::port_idx_t route_port;
    logic                     route_valid;
    logic                     route_ready;

    eth_route_lookup #(
        .NUM_PORTS (NUM_PORTS)
    ) lookup0 (
        .clk          (clk),
        .rst          (rst),
        .hdr_in       (hdr_in),
        .hdr_in_valid (hdr_in_valid),
        .hdr_in_ready (hdr_in_ready),
        .route_hdr    (route_hdr),
        .route_port   (route_port),
        .route_valid  (route_valid),
        .route_ready  (route_ready)
    );

    // payload bypasses the lookup and enters the demux directly
    eth_demux #(
        .NUM_PORTS (NUM_PORTS)
    ) demux0 (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .route_hdr     (route_hdr),
        .route_port    (route_port),
        .route_valid   (route_valid),
        .route_ready   (route_ready),
        .pay_in        (pay_in),
        .pay_in_valid  (pay_in_valid),
        .pay_in_ready  (pay_in_ready),
        .hdr_out       (hdr_out),
        .hdr_out_valid (hdr_out_valid),
        .hdr_out_ready (hdr_out_ready),
        .pay_out       (pay_out),
        .pay_out_valid (pay_out_valid),
        .pay_out_ready (pay_out_ready)
    );

endmodule

`default_nettype wire

/* tests/eth_frame_router_props.sv */
// Concurrent checks on the frame router outputs, bound into every eth_frame_router instance
`default_nettype none

module eth_frame_router_props #(
    parameter int NUM_PORTS = 4
) (
    input wire                           clk,
    input wire                           rst,
    input wire [NUM_PORTS-1:0]           hdr_out_valid,
    input wire eth_frame_pkg::eth_beat_t pay_out,
    input wire [NUM_PORTS-1:0]           pay_out_valid,
    input wire [NUM_PORTS-1:0]           pay_out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // outputs share one data bus, so only one port may be offered at a time
    hdr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hdr_out_valid))
        else $error("hdr_out_valid has more than one bit set: %h", hdr_out_valid);

    pay_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(pay_out_valid))
        else $error("pay_out_valid has more than one bit set: %h", pay_out_valid);

    // an offered beat stays put until its port takes it
    pay_hold: assert property (@(posedge clk) disable iff (rst)
        ((pay_out_valid != '0) && ((pay_out_valid & pay_out_ready) == '0))
        |=> ((pay_out_valid == $past(pay_out_valid)) && (pay_out == $past(pay_out))))
        else $error("pay_out or pay_out_valid changed before the port was ready");

    // nothing is offered in the cycle after reset release
    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |=> ((hdr_out_valid == '0) && (pay_out_valid == '0)))
        else $error("output valid high in the cycle after reset release");

endmodule

bind eth_frame_router eth_frame_router_props #(
    .NUM_PORTS (NUM_PORTS)
) props0 (
    .clk           (clk),
    .rst           (rst),
    .hdr_out_valid (hdr_out_valid),
    .pay_out       (pay_out),
    .pay_out_valid (pay_out_valid),
    .pay_out_ready (pay_out_ready)
);

`default_nettype wire

/* tests/tb_eth_frame_router.sv */
// Table-driven testbench for the frame router; sends each table frame and checks its output port
`default_nettype none

module tb_eth_frame_router;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS  = 4;
    localparam int NUM_FRAMES = 10;

    // one table row: header, payload shape, test controls, expected port
    typedef struct packed {
        eth_frame_pkg::eth_type_t eth_type;
        eth_frame_pkg::mac_addr_t dest_mac;
        eth_frame_pkg::mac_addr_t src_mac;
        logic [4:0]               len;
        logic                     user;
        logic                     bp;
        logic [3:0]               hold;
        logic [1:0]               port;
    } frame_row_t;

    logic                     clk;
    logic                     rst;
    logic                     enable;
    eth_frame_pkg::eth_hdr_t  hdr_in;
    logic                     hdr_in_valid;
    logic                     hdr_in_ready;
    eth_frame_pkg::eth_beat_t pay_in;
    logic                     pay_in_valid;
    logic                     pay_in_ready;
    eth_frame_pkg::eth_hdr_t  hdr_out;
    logic [NUM_PORTS-1:0]     hdr_out_valid;
    logic [NUM_PORTS-1:0]     hdr_out_ready;
    eth_frame_pkg::eth_beat_t pay_out;
    logic [NUM_PORTS-1:0]     pay_out_valid;
    logic [NUM_PORTS-1:0]     pay_out_ready;

    frame_row_t rows [NUM_FRAMES];
    int         frame_errs [NUM_FRAMES];
    logic       hdr_seen [NUM_FRAMES];
    logic       pay_seen [NUM_FRAMES];
    int         error_count = 0;
    int         hdr_count = 0;
    int         pay_frame = 0;
    int         pay_idx = 0;
    int         cycle_count = 0;
    int         timeout_limit;
    int         clean_count;
    integer     seed;
    logic       en_at_edge = 1'b1;
    logic       pay_stalled = 1'b0;
    logic [NUM_PORTS-1:0]     prev_hdr_valid = '0;
    logic [NUM_PORTS-1:0]     prev_pay_valid = '0;
    eth_frame_pkg::eth_beat_t prev_pay = '0;

    eth_frame_router #(
        .NUM_PORTS (NUM_PORTS)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .hdr_in        (hdr_in),
        .hdr_in_valid  (hdr_in_valid),
        .hdr_in_ready  (hdr_in_ready),
        .pay_in        (pay_in),
        .pay_in_valid  (pay_in_valid),
        .pay_in_ready  (pay_in_ready),
        .hdr_out       (hdr_out),
        .hdr_out_valid (hdr_out_valid),
        .hdr_out_ready (hdr_out_ready),
        .pay_out       (pay_out),
        .pay_out_valid (pay_out_valid),
        .pay_out_ready (pay_out_ready)
    );

    function automatic frame_row_t make_row(input logic [15:0] eth_type,
                                            input logic [47:0] dest_mac,
                                            input logic [47:0] src_mac, input int len,
                                            input int user, input int bp, input int hold,
                                            input int port);
        frame_row_t r;
        r.eth_type = eth_type;
        r.dest_mac = dest_mac;
        r.src_mac  = src_mac;
        r.len      = 5'(len);
        r.user     = 1'(user);
        r.bp       = 1'(bp);
        r.hold     = 4'(hold);
        r.port     = 2'(port);
        return r;
    endfunction

    function automatic eth_frame_pkg::eth_hdr_t row_header(input frame_row_t r);
        eth_frame_pkg::eth_hdr_t h;
        h.dest_mac = r.dest_mac;
        h.src_mac  = r.src_mac;
        h.eth_type = r.eth_type;
        return h;
    endfunction

    // type, dest, src, length, user on last, back-pressure, enable hold, expected port
    task automatic load_table();
        rows[0] = make_row(16'h0800, 48'h01005e000001, 48'h020000000a01, 6, 0, 0, 0, 0);
        rows[1] = make_row(16'h0806, 48'hffffffffffff, 48'h020000000a02, 4, 0, 0, 0, 1);
        rows[2] = make_row(16'h86dd, 48'h333300000001, 48'h020000000a03, 8, 0, 0, 0, 2);
        rows[3] = make_row(16'h88cc, 48'h0180c200000e, 48'h020000000a04, 5, 0, 0, 0, 3);
        rows[4] = make_row(16'h0800, 48'h020000000b01, 48'h020000000a05, 12, 0, 1, 0, 0);
        rows[5] = make_row(16'h86dd, 48'h020000000b02, 48'h020000000a06, 9, 1, 1, 0, 2);
        rows[6] = make_row(16'h0806, 48'h020000000b03, 48'h020000000a07, 3, 0, 0, 8, 1);
        rows[7] = make_row(16'h88b5, 48'h020000000b04, 48'h020000000a08, 1, 1, 0, 0, 3);
        rows[8] = make_row(16'h86dd, 48'h020000000b05, 48'h020000000a09, 16, 0, 1, 0, 2);
        rows[9] = make_row(16'h0806, 48'h020000000b06, 48'h020000000a0a, 2, 1, 1, 0, 1);
    endtask

    task automatic note_error(input int k);
        error_count++;
        if (k >= 0 && k < NUM_FRAMES) begin
            frame_errs[k]++;
        end
    endtask

    task automatic report_test(input int k);
        if (frame_errs[k] == 0) begin
            $display("test %0d: pass, type %h on port %0d, %0d bytes", k, rows[k].eth_type,
                     rows[k].port, rows[k].len);
        end else begin
            $display("test %0d: fail, %0d errors", k, frame_errs[k]);
        end
    endtask

    task automatic send_headers();
        for (int k = 0; k < NUM_FRAMES; k++) begin
            // hold frames start from an idle router so enable is the only thing holding them
            if (rows[k].hold != 0) begin
                while (pay_frame < k) @(negedge clk);
                enable = 1'b0;
            end
            hdr_in       = row_header(rows[k]);
            hdr_in_valid = 1'b1;
            while (!hdr_in_ready) @(negedge clk);
            @(negedge clk);
            hdr_in_valid = 1'b0;
            if (rows[k].hold != 0) begin
                repeat (rows[k].hold) @(negedge clk);
                enable = 1'b1;
            end
        end
    endtask

    task automatic send_payloads();
        for (int k = 0; k < NUM_FRAMES; k++) begin
            for (int i = 0; i < rows[k].len; i++) begin
                pay_in.data  = 8'(k * 16 + i);
                pay_in.last  = (i == rows[k].len - 1);
                pay_in.user  = pay_in.last && rows[k].user;
                pay_in_valid = 1'b1;
                while (!pay_in_ready) @(negedge clk);
                @(negedge clk);
            end
        end
        pay_in_valid = 1'b0;
    endtask

    task automatic check_header();
        int k;
        logic [NUM_PORTS-1:0] exp_valid;
        eth_frame_pkg::eth_hdr_t exp_hdr;
        k = hdr_count;
        if (k >= NUM_FRAMES) begin
            note_error(-1);
            $display("an extra header was taken from hdr_out after the last frame");
            return;
        end
        exp_valid = NUM_PORTS'(1) << rows[k].port;
        exp_hdr   = row_header(rows[k]);
        if (hdr_out_valid != exp_valid) begin
            note_error(k);
            $display("FAIL hdr_out_valid: got %h expected %h", hdr_out_valid, exp_valid);
        end
        if (hdr_out !== exp_hdr) begin
            note_error(k);
            $display("FAIL hdr_out: got %h expected %h", hdr_out, exp_hdr);
        end
        hdr_seen[k] = 1'b1;
        hdr_count++;
        if (pay_seen[k]) begin
            report_test(k);
        end
    endtask

    task automatic check_beat();
        int k;
        logic exp_last;
        logic [NUM_PORTS-1:0] exp_valid;
        eth_frame_pkg::eth_beat_t exp_beat;
        k = pay_frame;
        if (k >= NUM_FRAMES) begin
            note_error(-1);
            $display("an extra payload byte was taken from pay_out after the last frame");
            return;
        end
        exp_last      = (pay_idx == rows[k].len - 1);
        exp_valid     = NUM_PORTS'(1) << rows[k].port;
        exp_beat.data = 8'(k * 16 + pay_idx);
        exp_beat.last = exp_last;
        exp_beat.user = exp_last && rows[k].user;
        if (pay_out_valid != exp_valid) begin
            note_error(k);
            $display("FAIL pay_out_valid: got %h expected %h", pay_out_valid, exp_valid);
        end
        if (pay_out !== exp_beat) begin
            note_error(k);
            $display("FAIL pay_out: got %h expected %h", pay_out, exp_beat);
        end
        if (exp_last) begin
            pay_seen[k] = 1'b1;
            pay_frame++;
            pay_idx = 0;
            if (hdr_seen[k]) begin
                report_test(k);
            end
        end else begin
            pay_idx++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        en_at_edge <= enable;
    end

    // output side: drive readiness, then record what the next rising edge transfers
    always @(negedge clk) begin : monitor
        logic bp;
        cycle_count++;
        bp = (pay_frame < NUM_FRAMES) ? rows[pay_frame].bp : 1'b0;
        if (bp) begin
            hdr_out_ready = NUM_PORTS'($random(seed));
            pay_out_ready = NUM_PORTS'($random(seed));
        end else begin
            hdr_out_ready = '1;
            pay_out_ready = '1;
        end
        if ($countones(hdr_out_valid) > 1 || $countones(pay_out_valid) > 1) begin
            note_error(pay_frame);
            $display("more than one output port is offered data at the same time");
        end
        if ((hdr_out_valid & ~prev_hdr_valid) != '0 && !en_at_edge) begin
            note_error(hdr_count);
            $display("a header was released to an output while enable was low");
        end
        if (pay_stalled && (pay_out_valid != prev_pay_valid || pay_out !== prev_pay)) begin
            note_error(pay_frame);
            $display("FAIL pay_out: got %h expected %h while stalled", pay_out, prev_pay);
        end
        prev_hdr_valid = hdr_out_valid;
        prev_pay_valid = pay_out_valid;
        prev_pay       = pay_out;
        pay_stalled    = (pay_out_valid != '0) && ((pay_out_valid & pay_out_ready) == '0);
        if ((hdr_out_valid & hdr_out_ready) != '0) begin
            check_header();
        end
        if ((pay_out_valid & pay_out_ready) != '0) begin
            check_beat();
        end
    end

    initial begin
        seed          = 32'h7e0b_c27d;
        rst           = 1'b1;
        enable        = 1'b1;
        hdr_in        = '0;
        hdr_in_valid  = 1'b0;
        pay_in        = '0;
        pay_in_valid  = 1'b0;
        hdr_out_ready = '0;
        pay_out_ready = '0;
        load_table();
        timeout_limit = 10;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            frame_errs[k] = 0;
            hdr_seen[k]   = 1'b0;
            pay_seen[k]   = 1'b0;
            timeout_limit += (rows[k].len + 1 + 10) * 4;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (hdr_in_ready || pay_in_ready || hdr_out_valid != '0 || pay_out_valid != '0) begin
            note_error(-1);
            $display("handshake outputs are not all low during reset");
        end
        rst = 1'b0;
        fork
            send_headers();
            send_payloads();
        join_none
        while ((hdr_count < NUM_FRAMES || pay_frame < NUM_FRAMES) &&
               cycle_count < timeout_limit) begin
            @(posedge clk);
        end
        if (hdr_count < NUM_FRAMES || pay_frame < NUM_FRAMES) begin
            note_error(-1);
            $display("timeout after %0d cycles with %0d headers and %0d frames received",
                     cycle_count, hdr_count, pay_frame);
        end
        clean_count = 0;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            if (hdr_seen[k] && pay_seen[k] && frame_errs[k] == 0) begin
                clean_count++;
            end
        end
        $display("%0d of %0d tests clean, %0d errors", clean_count, NUM_FRAMES, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/eth_frame_pkg.sv
verilog/eth_route_pkg.sv
verilog/eth_route_lookup.sv
verilog/eth_demux.sv
verilog/eth_frame_router.sv
tests/eth_frame_router_props.sv
tests/tb_eth_frame_router.sv

/* Bender.yml */
package:
  name: eth_frame_router

sources:
  # packages first, then the RTL from the leaves up
  - verilog/eth_frame_pkg.sv
  - verilog/eth_route_pkg.sv
  - verilog/eth_route_lookup.sv
  - verilog/eth_demux.sv
  - verilog/eth_frame_router.sv

  - target: test
    files:
      - tests/eth_frame_router_props.sv
      - tests/tb_eth_frame_router.sv
